// File: common/cpu_pkg.sv
package cpu_pkg;

    // ========================================================================
    // Sizes and flag positions
    localparam int MEM_ADDR_BITS = 8;
    localparam int PC_BITS       = 16;
    localparam int FLAG_BITS     = 3;
    localparam int FLAG_ZERO     = 0;
    localparam int FLAG_CARRY    = 1;                 // Set on carry out or borrow
    localparam int FLAG_NEGATIVE = 2;

    // ========================================================================
    // Instruction set
    typedef enum logic [7:0] {
        NOP   = 8'h00,
        HLT   = 8'h01,
        ADD_B = 8'h10,
        ADD_C = 8'h11,
        ADC_B = 8'h12,
        ADC_C = 8'h13,
        SUB_B = 8'h14,
        SUB_C = 8'h15,
        SBC_B = 8'h16,
        SBC_C = 8'h17,
        ANA_B = 8'h18,
        ANA_C = 8'h19,
        INR_A = 8'h1A,
        DCR_A = 8'h1B,
        ANI   = 8'h1C,                                // One operand, AND immediate
        LDI_A = 8'h20,
        LDI_B = 8'h21,
        LDI_C = 8'h22,
        JMP   = 8'h30,                                // Operands are low then high byte
        JZ    = 8'h31,
        JNZ   = 8'h32,
        JN    = 8'h33,
        LDA   = 8'h40
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_UNDEFINED = 3'd0,                         // Result register holds its value
        ALU_ADD       = 3'd1,
        ALU_ADC       = 3'd2,
        ALU_SUB       = 3'd3,
        ALU_SBC       = 3'd4,
        ALU_INR       = 3'd5,
        ALU_DCR       = 3'd6,
        ALU_AND       = 3'd7
    } alu_op_t;

    // ========================================================================
    // Sequencing
    typedef enum logic [2:0] {
        S_RESET, S_INIT, S_LATCH_ADDR, S_READ_BYTE,
        S_LATCH_BYTE, S_CHK_MORE_BYTES, S_EXECUTE, S_HALT
    } fsm_state_t;

    typedef enum logic [2:0] {
        MS0, MS1, MS2, MS3, MS4, MS5, MS6, MS7
    } microstep_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src_c;                           // Second ALU operand is C, else B
        logic    load_origin;
        logic    load_mar_pc;
        logic    pc_enable;
        logic    oe_ram;
        logic    load_ir;
        logic    load_temp_1;
        logic    load_temp_2;
        logic    oe_temp_1;
        logic    oe_temp_2;
        logic    oe_alu;
        logic    load_a;
        logic    load_b;
        logic    load_c;
        logic    load_flags;
        logic    load_sets_zn;                        // Zero and negative from the bus
        logic    load_pc_low_byte;
        logic    load_pc_high_byte;
        logic    load_mar_addr_low;
        logic    load_mar_addr_high;
        logic    check_zero;
        logic    check_not_zero;
        logic    check_carry;
        logic    check_negative;
        logic    last_step;
        logic    halt;
    } control_word_t;

endpackage

// File: common/ctrl_if.sv
`timescale 1ns/100ps

interface ctrl_if;

    cpu_pkg::control_word_t           control_word;
    cpu_pkg::opcode_t                 opcode;      // Instruction register
    logic [cpu_pkg::FLAG_BITS-1:0]    flags;
    logic                             halted;

    modport ctrl (
        output control_word, halted,
        input  opcode, flags
    );

    modport dp (
        output opcode, flags,
        input  control_word
    );

endinterface

// File: control_unit/control_unit.sv
`timescale 1ns/100ps

module control_unit (
    input  logic clk,
    input  logic reset,
    ctrl_if.ctrl ctrl
);

    cpu_pkg::fsm_state_t    state;
    cpu_pkg::fsm_state_t    next_state;
    cpu_pkg::microstep_t    microstep;
    cpu_pkg::microstep_t    next_microstep;
    logic [1:0]             byte_count;                   // Bytes of this instruction so far
    logic [1:0]             next_byte_count;
    logic [1:0]             num_operand_bytes;
    cpu_pkg::control_word_t rom_word;
    cpu_pkg::control_word_t cw;
    logic                   check_jump;
    logic                   jump_taken;

    // ========================================================================
    // Microcode ROM, indexed by opcode and microstep
    function automatic cpu_pkg::control_word_t microcode(cpu_pkg::opcode_t op,
                                                         cpu_pkg::microstep_t step);
        cpu_pkg::control_word_t w;
        w = '0;
        case (op)
            cpu_pkg::HLT: w.halt = 1'b1;
            cpu_pkg::JMP, cpu_pkg::JZ, cpu_pkg::JNZ, cpu_pkg::JN: begin
                w.check_zero     = (op == cpu_pkg::JZ);   // Checked on both steps
                w.check_not_zero = (op == cpu_pkg::JNZ);
                w.check_negative = (op == cpu_pkg::JN);
                if (step == cpu_pkg::MS0) begin
                    w.oe_temp_1        = 1'b1;
                    w.load_pc_low_byte = 1'b1;
                end else begin
                    w.oe_temp_2         = 1'b1;
                    w.load_pc_high_byte = 1'b1;
                    w.last_step         = 1'b1;
                end
            end
            cpu_pkg::ADD_B, cpu_pkg::ADD_C, cpu_pkg::ADC_B, cpu_pkg::ADC_C,
            cpu_pkg::SUB_B, cpu_pkg::SUB_C, cpu_pkg::SBC_B, cpu_pkg::SBC_C,
            cpu_pkg::ANA_B, cpu_pkg::ANA_C, cpu_pkg::INR_A, cpu_pkg::DCR_A,
            cpu_pkg::ANI: begin
                if (step == cpu_pkg::MS0) begin
                    case (op)
                        cpu_pkg::ADD_B, cpu_pkg::ADD_C: w.alu_op = cpu_pkg::ALU_ADD;
                        cpu_pkg::ADC_B, cpu_pkg::ADC_C: w.alu_op = cpu_pkg::ALU_ADC;
                        cpu_pkg::SUB_B, cpu_pkg::SUB_C: w.alu_op = cpu_pkg::ALU_SUB;
                        cpu_pkg::SBC_B, cpu_pkg::SBC_C: w.alu_op = cpu_pkg::ALU_SBC;
                        cpu_pkg::INR_A:                 w.alu_op = cpu_pkg::ALU_INR;
                        cpu_pkg::DCR_A:                 w.alu_op = cpu_pkg::ALU_DCR;
                        default:                        w.alu_op = cpu_pkg::ALU_AND;
                    endcase
                    w.alu_src_c = op inside {cpu_pkg::ADD_C, cpu_pkg::ADC_C,
                                             cpu_pkg::SUB_C, cpu_pkg::SBC_C,
                                             cpu_pkg::ANA_C};
                end else begin
                    w.oe_alu     = 1'b1;                  // Result registered last cycle
                    w.load_a     = 1'b1;
                    w.load_flags = 1'b1;
                    w.last_step  = 1'b1;
                end
            end
            cpu_pkg::LDI_A, cpu_pkg::LDI_B, cpu_pkg::LDI_C: begin
                w.oe_temp_1    = 1'b1;
                w.load_a       = (op == cpu_pkg::LDI_A);
                w.load_b       = (op == cpu_pkg::LDI_B);
                w.load_c       = (op == cpu_pkg::LDI_C);
                w.load_flags   = 1'b1;
                w.load_sets_zn = 1'b1;
                w.last_step    = 1'b1;
            end
            cpu_pkg::LDA: begin
                case (step)
                    cpu_pkg::MS0: begin
                        w.oe_temp_1         = 1'b1;
                        w.load_mar_addr_low = 1'b1;
                    end
                    cpu_pkg::MS1: begin
                        w.oe_temp_2          = 1'b1;
                        w.load_mar_addr_high = 1'b1;
                    end
                    cpu_pkg::MS2: w.oe_ram = 1'b1;        // Read settles
                    default: begin
                        w.oe_ram       = 1'b1;
                        w.load_a       = 1'b1;
                        w.load_flags   = 1'b1;
                        w.load_sets_zn = 1'b1;
                        w.last_step    = 1'b1;
                    end
                endcase
            end
            default: w.last_step = 1'b1;                  // NOP and unknown opcodes
        endcase
        return w;
    endfunction

    always_comb begin
        case (ctrl.opcode)
            cpu_pkg::LDI_A, cpu_pkg::LDI_B, cpu_pkg::LDI_C, cpu_pkg::ANI:
                num_operand_bytes = 2'd1;
            cpu_pkg::JMP, cpu_pkg::JZ, cpu_pkg::JNZ, cpu_pkg::JN, cpu_pkg::LDA:
                num_operand_bytes = 2'd2;
            default:
                num_operand_bytes = 2'd0;
        endcase
    end

    assign rom_word   = microcode(ctrl.opcode, microstep);
    assign check_jump = rom_word.check_zero | rom_word.check_not_zero |
                        rom_word.check_carry | rom_word.check_negative;
    assign jump_taken = (rom_word.check_zero     &  ctrl.flags[cpu_pkg::FLAG_ZERO])  |
                        (rom_word.check_not_zero & ~ctrl.flags[cpu_pkg::FLAG_ZERO])  |
                        (rom_word.check_carry    &  ctrl.flags[cpu_pkg::FLAG_CARRY]) |
                        (rom_word.check_negative &  ctrl.flags[cpu_pkg::FLAG_NEGATIVE]);

    // ========================================================================
    // Fetch and execute sequencing
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= cpu_pkg::S_RESET;
            microstep  <= cpu_pkg::MS0;
            byte_count <= 2'd0;
        end else begin
            state      <= next_state;
            microstep  <= next_microstep;
            byte_count <= next_byte_count;
        end
    end

    always_comb begin
        next_state      = state;
        next_microstep  = microstep;
        next_byte_count = byte_count;
        cw              = '0;
        case (state)
            cpu_pkg::S_RESET: next_state = cpu_pkg::S_INIT;
            cpu_pkg::S_INIT: begin
                cw.load_origin = 1'b1;                    // PC to zero
                next_state     = cpu_pkg::S_LATCH_ADDR;
            end
            cpu_pkg::S_LATCH_ADDR: begin
                cw.load_mar_pc = 1'b1;
                next_state     = cpu_pkg::S_READ_BYTE;
            end
            cpu_pkg::S_READ_BYTE: begin
                cw.oe_ram  = 1'b1;
                next_state = cpu_pkg::S_LATCH_BYTE;
            end
            cpu_pkg::S_LATCH_BYTE: begin
                cw.oe_ram      = 1'b1;
                cw.pc_enable   = 1'b1;
                cw.load_ir     = (byte_count == 2'd0);
                cw.load_temp_1 = (byte_count == 2'd1);
                cw.load_temp_2 = (byte_count == 2'd2);
                next_state     = cpu_pkg::S_CHK_MORE_BYTES;
            end
            cpu_pkg::S_CHK_MORE_BYTES: begin
                if (byte_count == num_operand_bytes) begin
                    next_state      = cpu_pkg::S_EXECUTE;
                    next_byte_count = 2'd0;
                end else begin
                    next_state      = cpu_pkg::S_LATCH_ADDR;
                    next_byte_count = byte_count + 2'd1;
                end
            end
            cpu_pkg::S_EXECUTE: begin
                cw = rom_word;
                if (rom_word.halt) begin
                    next_state     = cpu_pkg::S_HALT;
                    next_microstep = cpu_pkg::MS0;
                end else if (check_jump && !jump_taken) begin
                    cw.load_pc_low_byte  = 1'b0;          // PC stays after the operands
                    cw.load_pc_high_byte = 1'b0;
                    next_state           = cpu_pkg::S_LATCH_ADDR;
                    next_microstep       = cpu_pkg::MS0;
                end else if (rom_word.last_step) begin
                    next_state     = cpu_pkg::S_LATCH_ADDR;
                    next_microstep = cpu_pkg::MS0;
                end else begin
                    next_microstep = cpu_pkg::microstep_t'(microstep + 3'd1);
                end
            end
            default: next_state = cpu_pkg::S_HALT;        // Left only through reset
        endcase
    end

    assign ctrl.control_word = cw;
    assign ctrl.halted       = (state == cpu_pkg::S_HALT);

    // ========================================================================
    // Checks
    state_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(state));

    byte_count_range: assert property (@(posedge clk) disable iff (reset)
        byte_count <= 2'd2);

endmodule

// File: datapath/datapath.sv
`timescale 1ns/100ps

module datapath (
    input  logic                              clk,
    input  logic                              reset,
    ctrl_if.dp                                dp,
    output logic [cpu_pkg::MEM_ADDR_BITS-1:0] mem_addr,
    input  logic [7:0]                        mem_rdata,
    output logic [7:0]                        reg_a,
    output logic [cpu_pkg::FLAG_BITS-1:0]     flags,
    output logic [cpu_pkg::PC_BITS-1:0]       pc
);

    cpu_pkg::control_word_t            cw;
    cpu_pkg::opcode_t                  ir;
    logic [7:0]                        reg_b;
    logic [7:0]                        reg_c;
    logic [7:0]                        temp_1;
    logic [7:0]                        temp_2;
    logic [cpu_pkg::PC_BITS-1:0]       mar;
    logic [7:0]                        bus;
    logic [7:0]                        alu_operand;
    logic [8:0]                        alu_sum;       // Bit 8 is carry or borrow
    logic [7:0]                        alu_result;
    logic [cpu_pkg::FLAG_BITS-1:0]     alu_flags;
    logic                              carry_in;

    assign cw       = dp.control_word;
    assign carry_in = flags[cpu_pkg::FLAG_CARRY];

    // ========================================================================
    // Internal bus and ALU
    always_comb begin
        if (cw.oe_ram) begin
            bus = mem_rdata;
        end else if (cw.oe_alu) begin
            bus = alu_result;
        end else if (cw.oe_temp_1) begin
            bus = temp_1;
        end else if (cw.oe_temp_2) begin
            bus = temp_2;
        end else begin
            bus = 8'd0;                                 // Nothing driving
        end
    end

    assign alu_operand = (ir == cpu_pkg::ANI) ? temp_1 :
                         cw.alu_src_c         ? reg_c  : reg_b;

    always_comb begin
        case (cw.alu_op)
            cpu_pkg::ALU_ADD: alu_sum = {1'b0, reg_a} + {1'b0, alu_operand};
            cpu_pkg::ALU_ADC: alu_sum = {1'b0, reg_a} + {1'b0, alu_operand} + 9'(carry_in);
            cpu_pkg::ALU_SUB: alu_sum = {1'b0, reg_a} - {1'b0, alu_operand};
            cpu_pkg::ALU_SBC: alu_sum = {1'b0, reg_a} - {1'b0, alu_operand} - 9'(carry_in);
            cpu_pkg::ALU_INR: alu_sum = {1'b0, reg_a} + 9'd1;
            cpu_pkg::ALU_DCR: alu_sum = {1'b0, reg_a} - 9'd1;
            cpu_pkg::ALU_AND: alu_sum = {1'b0, reg_a & alu_operand};  // Carry cleared
            default:          alu_sum = 9'd0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (cw.alu_op != cpu_pkg::ALU_UNDEFINED) begin
            alu_result                        <= alu_sum[7:0];
            alu_flags[cpu_pkg::FLAG_ZERO]     <= (alu_sum[7:0] == 8'd0);
            alu_flags[cpu_pkg::FLAG_CARRY]    <= alu_sum[8];
            alu_flags[cpu_pkg::FLAG_NEGATIVE] <= alu_sum[7];
        end
        if (cw.load_temp_1) temp_1 <= bus;
        if (cw.load_temp_2) temp_2 <= bus;
    end

    // ========================================================================
    // Architectural registers, PC and MAR
    always_ff @(posedge clk) begin
        if (reset) begin
            ir    <= cpu_pkg::NOP;
            reg_a <= 8'd0;
            reg_b <= 8'd0;
            reg_c <= 8'd0;
            flags <= '0;
            pc    <= '0;
            mar   <= '0;
        end else begin
            if (cw.load_ir) ir <= cpu_pkg::opcode_t'(bus);
            if (cw.load_a)  reg_a <= bus;
            if (cw.load_b)  reg_b <= bus;
            if (cw.load_c)  reg_c <= bus;
            if (cw.load_flags) begin
                if (cw.load_sets_zn) begin
                    flags[cpu_pkg::FLAG_ZERO]     <= (bus == 8'd0);  // Carry kept
                    flags[cpu_pkg::FLAG_NEGATIVE] <= bus[7];
                end else begin
                    flags <= alu_flags;
                end
            end
            if (cw.load_origin) begin
                pc <= '0;
            end else if (cw.pc_enable) begin
                pc <= pc + 1'b1;
            end
            if (cw.load_pc_low_byte)  pc[7:0]  <= bus;
            if (cw.load_pc_high_byte) pc[15:8] <= bus;
            if (cw.load_mar_pc)        mar       <= pc;
            if (cw.load_mar_addr_low)  mar[7:0]  <= bus;
            if (cw.load_mar_addr_high) mar[15:8] <= bus;
        end
    end

    assign mem_addr  = mar[cpu_pkg::MEM_ADDR_BITS-1:0];
    assign dp.opcode = ir;
    assign dp.flags  = flags;

    bus_single_driver: assert property (@(posedge clk) disable iff (reset)
        $onehot0({cw.oe_ram, cw.oe_alu, cw.oe_temp_1, cw.oe_temp_2}));

endmodule

// File: source/program_memory.sv
`timescale 1ns/100ps

module program_memory (
    input  logic                              clk,
    input  logic                              we,
    input  logic [cpu_pkg::MEM_ADDR_BITS-1:0] waddr,
    input  logic [7:0]                        wdata,
    input  logic [cpu_pkg::MEM_ADDR_BITS-1:0] raddr,
    output logic [7:0]                        rdata
);

    logic [7:0] mem [2**cpu_pkg::MEM_ADDR_BITS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;                        // Loaded while the CPU is in reset
        end
    end

    assign rdata = mem[raddr];                          // Same-cycle read

endmodule

// File: source/cpu_top.sv
`timescale 1ns/100ps

module cpu_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              prog_we,
    input  logic [cpu_pkg::MEM_ADDR_BITS-1:0] prog_addr,
    input  logic [7:0]                        prog_data,
    output logic                              halted,
    output logic [7:0]                        reg_a,
    output logic [cpu_pkg::FLAG_BITS-1:0]     flags,
    output logic [cpu_pkg::PC_BITS-1:0]       pc
);

    logic [cpu_pkg::MEM_ADDR_BITS-1:0] mem_addr;
    logic [7:0]                        mem_rdata;

    ctrl_if i_ctrl_if ();

    control_unit i_control_unit (
        .clk   (clk),
        .reset (reset),
        .ctrl  (i_ctrl_if.ctrl)
    );

    datapath i_datapath (
        .clk       (clk),
        .reset     (reset),
        .dp        (i_ctrl_if.dp),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata),
        .reg_a     (reg_a),
        .flags     (flags),
        .pc        (pc)
    );

    program_memory i_program_memory (
        .clk   (clk),
        .we    (prog_we),
        .waddr (prog_addr),
        .wdata (prog_data),
        .raddr (mem_addr),
        .rdata (mem_rdata)
    );

    assign halted = i_ctrl_if.halted;

endmodule

// File: tb/cpu_tb.sv
`timescale 1ns/100ps

module cpu_tb;

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 16;
    localparam int MID_RESET_HOLD  = 4;                   // Cycles of a mid-program reset
    localparam int CYCLES_PER_TEST = 400;
    localparam int TEST_WORDS      = 1024;

    logic                              clk;
    logic                              reset;
    logic                              prog_we;
    logic [cpu_pkg::MEM_ADDR_BITS-1:0] prog_addr;
    logic [7:0]                        prog_data;
    logic                              halted;
    logic [7:0]                        reg_a;
    logic [cpu_pkg::FLAG_BITS-1:0]     flags;
    logic [cpu_pkg::PC_BITS-1:0]       pc;

    logic [15:0]                       words [TEST_WORDS];
    int                                num_tests = 0;

    cpu_top i_cpu_top (
        .clk       (clk),
        .reset     (reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .halted    (halted),
        .reg_a     (reg_a),
        .flags     (flags),
        .pc        (pc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ========================================================================
    // Helpers
    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_for_halt();
        while (halted !== 1'b1) @(negedge clk);           // Watchdog bounds this
    endtask

    task automatic load_program(input int first, input int count);
        int i;
        for (i = 0; i < count; i++) begin
            prog_we   = 1'b1;
            prog_addr = 8'(i);
            prog_data = words[first + i][7:0];
            @(negedge clk);
        end
        prog_we = 1'b0;
    endtask

    // ========================================================================
    // Watchdog
    initial begin
        wait (num_tests > 0);
        #(num_tests * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Timeout: the CPU did not halt within the expected time");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    // ========================================================================
    // Test sequence
    initial begin
        int idx;
        int t;
        int reset_at;
        int nbytes;
        reset     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        $readmemh("tb/cpu_tests.txt", words);
        if ($isunknown(words[0]) || words[0] == 16'd0) begin
            $display("The test file could not be read or holds no tests");
            $display("Simulation failed");
            $fatal(1, "no tests");
        end
        num_tests = int'(words[0]);
        idx       = 1;
        for (t = 0; t < num_tests; t++) begin
            reset_at = int'(words[idx]);
            nbytes   = int'(words[idx + 1]);
            if (nbytes > 256 || idx + nbytes + 5 > TEST_WORDS) begin
                $display("Test %0d in the test file is malformed", t);
                $display("Simulation failed");
                $fatal(1, "bad test record");
            end
            @(negedge clk);
            reset = 1'b1;
            wait_cycles(RESET_CYCLES);
            load_program(idx + 2, nbytes);                // Memory written under reset
            reset = 1'b0;
            if (reset_at > 0) begin
                wait_cycles(reset_at);
                reset = 1'b1;                             // Restart in mid-program
                wait_cycles(MID_RESET_HOLD);
                check_value($sformatf("test %0d halted in reset", t), 16'd0, {15'd0, halted});
                check_value($sformatf("test %0d pc in reset", t), 16'd0, pc);
                check_value($sformatf("test %0d reg_a in reset", t), 16'd0, {8'd0, reg_a});
                reset = 1'b0;
            end
            wait_for_halt();
            check_value($sformatf("test %0d reg_a", t), words[idx + 2 + nbytes], {8'd0, reg_a});
            check_value($sformatf("test %0d flags", t), words[idx + 3 + nbytes],
                        {13'd0, flags});
            check_value($sformatf("test %0d pc", t), words[idx + 4 + nbytes], pc);
            idx = idx + nbytes + 5;
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: tb/cpu_tests.txt
// Columns: reset cycle in mid-run (0 for none), byte count, program bytes, expected A, flags, PC
// All hex; flags hold negative, carry and zero in bits 2, 1 and 0
0011
0 9 20 F0 21 20 22 05 10 13 01 16 0 9
0 9 20 03 21 05 14 22 01 17 01 FC 4 9
0 6 20 42 22 42 15 01 00 1 6
0 9 20 7F 22 01 11 21 80 16 01 00 1 9
0 5 20 FF 1A 1B 01 FF 6 5
0 B 20 FF 1A 20 F3 22 3C 19 1C 0F 01 00 1 B
0 6 20 9C 21 F0 18 01 90 4 6
0 B 30 08 00 20 11 01 00 00 20 22 01 22 0 B
0 B 20 00 31 08 00 20 11 01 20 22 01 22 0 B
0 B 20 05 31 08 00 20 11 01 20 22 01 11 0 8
0 B 20 05 32 08 00 20 11 01 20 22 01 22 0 B
0 B 20 00 32 08 00 20 11 01 20 22 01 11 0 8
0 B 20 80 33 08 00 20 11 01 20 22 01 22 0 B
0 B 20 7F 33 08 00 20 11 01 20 22 01 11 0 8
0 11 20 FF 1A 40 10 00 01 00 00 00 00 00 00 00 00 00 80 80 6 7
0 B 20 01 40 0A 00 01 00 00 00 00 00 00 1 6
14 7 20 0F 1A 1A 1A 1A 01 13 0 7

// File: verilog.f
common/cpu_pkg.sv
common/ctrl_if.sv
control_unit/control_unit.sv
datapath/datapath.sv
source/program_memory.sv
source/cpu_top.sv
tb/cpu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module cpu_tb -f verilog.f

./obj_dir/Vcpu_tb
